//--- fp16Pkg.sv
package fp16Pkg;

	// Half precision word layout
	localparam int ExpWidth = 5;     // Biased exponent field
	localparam int ManWidth = 10;    // Stored fraction, hidden one not included
	localparam int WordWidth = 16;   // Sign + exponent + mantissa

	// Adder working format
	// Bits of the working sum from top to bottom are carry, hidden one, mantissa, guard
	localparam int GuardBits = 5;      // Extra low bits kept through the add
	localparam int SumWidth = 17;      // 1 + 1 + ManWidth + GuardBits
	localparam int MaxAlignShift = 12; // Smaller operand drops out at this shift

	// Fetch loop
	localparam int NumElems = 8;     // Words summed per run
	localparam int IndexWidth = 4;   // Must be able to hold NumElems itself
	localparam int AddrWidth = 3;    // External memory address

	// Operand register, aligned register, result register
	localparam int AddLatency = 3;

	// Field view of one fp16 word
	typedef struct packed {
		logic                sign;
		logic [ExpWidth-1:0] exponent;
		logic [ManWidth-1:0] mantissa;
	} halfFields_s;

	// Memory and sum registers handle the raw word
	// Adder stages pick the same bits apart as fields
	typedef union packed {
		logic [WordWidth-1:0] raw;
		halfFields_s          fields;
	} halfWord_u;

endpackage

//--- fpAlign.sv
`timescale 1ns/1ps

module fpAlign (
	input  fp16Pkg::halfWord_u                  opA,
	input  fp16Pkg::halfWord_u                  opB,
	output logic [fp16Pkg::ExpWidth-1:0]        commonExp,    // Exponent of larger operand
	output logic                                bigSign,
	output logic                                smallSign,
	output logic [fp16Pkg::ManWidth:0]          bigMan,       // Hidden bit + mantissa
	output logic [fp16Pkg::SumWidth-1:0]        smallAligned  // Shifted into sum layout
);

	logic                              aIsBig;
	fp16Pkg::halfWord_u                bigOp;
	fp16Pkg::halfWord_u                smallOp;
	logic [fp16Pkg::ExpWidth-1:0]      expDiff;
	logic [fp16Pkg::SumWidth-1:0]      smallSig;
	logic                              tooFar;

	// Magnitude compare on exponent then mantissa, sign ignored
	// Ties keep A as the larger operand
	assign aIsBig = {opA.fields.exponent, opA.fields.mantissa} >=
		{opB.fields.exponent, opB.fields.mantissa};

	assign bigOp = aIsBig ? opA : opB;
	assign smallOp = aIsBig ? opB : opA;

	// Never negative since bigOp has the larger exponent
	assign expDiff = bigOp.fields.exponent - smallOp.fields.exponent;

	assign commonExp = bigOp.fields.exponent;
	assign bigSign = bigOp.fields.sign;
	assign smallSign = smallOp.fields.sign;

	// Hidden one only for a nonzero exponent field
	assign bigMan = {|bigOp.fields.exponent, bigOp.fields.mantissa};

	// Carry slot empty, guard bits zero before the shift
	assign smallSig = {
		1'b0,
		|smallOp.fields.exponent,
		smallOp.fields.mantissa,
		{fp16Pkg::GuardBits{1'b0}}
	};

	// Far below the larger operand, contributes nothing
	assign tooFar = (expDiff >= (fp16Pkg::ExpWidth)'(fp16Pkg::MaxAlignShift));

	// Bits shifted past the guard positions are dropped
	assign smallAligned = tooFar ? '0 : (smallSig >> expDiff);

endmodule

//--- fpNormalizeRound.sv
`timescale 1ns/1ps

module fpNormalizeRound (
	input  logic [fp16Pkg::ExpWidth-1:0]   commonExp,
	input  logic                           bigSign,
	input  logic                           smallSign,
	input  logic [fp16Pkg::ManWidth:0]     bigMan,
	input  logic [fp16Pkg::SumWidth-1:0]   smallAligned,
	output fp16Pkg::halfWord_u             result
);

	logic [fp16Pkg::SumWidth-1:0]   bigFull;    // Larger significand in sum layout
	logic [fp16Pkg::SumWidth-1:0]   rawSum;
	logic                           effSub;     // Signs differ
	logic                           zeroSum;
	logic [fp16Pkg::ExpWidth-1:0]   lz;         // Leading zeros above the leading one
	logic [fp16Pkg::SumWidth-1:0]   normSum;
	logic [fp16Pkg::ExpWidth-1:0]   normExp;
	logic [fp16Pkg::ManWidth-1:0]   normMan;
	logic                           roundBit;   // First dropped bit
	logic                           sticky;     // Anything below it
	logic                           roundUp;
	logic [fp16Pkg::ManWidth:0]     upMan;      // Mantissa + 1 with carry out
	logic [fp16Pkg::ManWidth-1:0]   finalMan;
	logic [fp16Pkg::ExpWidth-1:0]   finalExp;

	assign bigFull = {1'b0, bigMan, {fp16Pkg::GuardBits{1'b0}}};
	assign effSub = bigSign ^ smallSign;

	// Larger magnitude first, so subtraction cannot go negative
	assign rawSum = effSub ? (bigFull - smallAligned) : (bigFull + smallAligned);
	assign zeroSum = ~|rawSum;

	// Leading one search, highest set bit wins
	always_comb begin
		lz = '0;
		for (int i = 0; i < fp16Pkg::SumWidth; i++) begin
			if (rawSum[i]) begin
				lz = (fp16Pkg::ExpWidth)'(fp16Pkg::SumWidth - 1 - i);
			end
		end
	end

	// Leading one moved up to the carry slot
	assign normSum = rawSum << lz;

	// Carry slot sits one above the hidden bit of commonExp
	assign normExp = commonExp + 1'b1 - lz;   // Wraps out of range, no flags

	assign normMan = normSum[fp16Pkg::GuardBits+1 +: fp16Pkg::ManWidth];
	assign roundBit = normSum[fp16Pkg::GuardBits];
	assign sticky = |normSum[fp16Pkg::GuardBits-1:0];

	// Nearest even, ties go to an even mantissa
	assign roundUp = roundBit & (sticky | normMan[0]);
	assign upMan = {1'b0, normMan} + 1'b1;

	always_comb begin
		if (roundUp) begin
			finalMan = upMan[fp16Pkg::ManWidth-1:0];
			// All ones mantissa rolls over into the exponent
			finalExp = normExp + {{(fp16Pkg::ExpWidth-1){1'b0}}, upMan[fp16Pkg::ManWidth]};
		end else begin
			finalMan = normMan;
			finalExp = normExp;
		end
	end

	always_comb begin
		result.raw = '0;
		if (zeroSum) begin
			// Exact cancellation is +0 unless both inputs were negative
			result.fields.sign = bigSign & smallSign;
		end else begin
			result.fields.sign = bigSign;
			result.fields.exponent = finalExp;
			result.fields.mantissa = finalMan;
		end
	end

endmodule

//--- fpAddPipe.sv
`timescale 1ns/1ps

module fpAddPipe (
	input  logic                ap_clk,
	input  fp16Pkg::halfWord_u  opA,
	input  fp16Pkg::halfWord_u  opB,
	output fp16Pkg::halfWord_u  addResult   // Sum of inputs from AddLatency cycles ago
);

	// Operand register
	fp16Pkg::halfWord_u                 opAReg;
	fp16Pkg::halfWord_u                 opBReg;

	// Align stage outputs and their register
	logic [fp16Pkg::ExpWidth-1:0]       commonExp;
	logic                               bigSign;
	logic                               smallSign;
	logic [fp16Pkg::ManWidth:0]         bigMan;
	logic [fp16Pkg::SumWidth-1:0]       smallAligned;
	logic [fp16Pkg::ExpWidth-1:0]       commonExpReg;
	logic                               bigSignReg;
	logic                               smallSignReg;
	logic [fp16Pkg::ManWidth:0]         bigManReg;
	logic [fp16Pkg::SumWidth-1:0]       smallAlignedReg;

	// Normalize stage output and result register
	fp16Pkg::halfWord_u                 sumWord;
	fp16Pkg::halfWord_u                 resultReg;

	fpAlign fpAlignInst (
		.opA          (opAReg),
		.opB          (opBReg),
		.commonExp    (commonExp),
		.bigSign      (bigSign),
		.smallSign    (smallSign),
		.bigMan       (bigMan),
		.smallAligned (smallAligned)
	);

	fpNormalizeRound fpNormalizeRoundInst (
		.commonExp    (commonExpReg),
		.bigSign      (bigSignReg),
		.smallSign    (smallSignReg),
		.bigMan       (bigManReg),
		.smallAligned (smallAlignedReg),
		.result       (sumWord)
	);

	// Free running, a new add can enter every cycle
	always_ff @(posedge ap_clk) begin
		opAReg <= opA;
		opBReg <= opB;
		commonExpReg <= commonExp;      // Stage boundary between align and normalize
		bigSignReg <= bigSign;
		smallSignReg <= smallSign;
		bigManReg <= bigMan;
		smallAlignedReg <= smallAligned;
		resultReg <= sumWord;
	end

	assign addResult = resultReg;

endmodule

//--- accumSequencer.sv
`timescale 1ns/1ps

module accumSequencer (
	input  logic                           ap_clk,
	input  logic                           ap_rst,
	input  logic                           ap_start,     // Level, sampled in Idle
	input  logic                           doneHeld,     // Previous result not yet taken
	input  fp16Pkg::halfWord_u             accumInQ,     // Read data, one cycle after enable
	input  fp16Pkg::halfWord_u             addResult,    // Adder output, AddLatency behind
	output logic [fp16Pkg::AddrWidth-1:0]  accumInAddr,
	output logic                           accumInCe,
	output logic                           ap_idle,
	output fp16Pkg::halfWord_u             opA,          // Running sum into adder
	output fp16Pkg::halfWord_u             opB,          // Fetched word into adder
	output logic                           finish,       // One cycle, end of run
	output fp16Pkg::halfWord_u             runSum
);

	enum logic [2:0] {Idle, Fetch, Load, Wait, Accumulate} state, stateNext;

	logic [fp16Pkg::IndexWidth-1:0]            index;    // Next element to read
	logic [$clog2(fp16Pkg::AddLatency)-1:0]    waitCnt;  // Cycles spent in Wait
	fp16Pkg::halfWord_u                        loadReg;  // Captured memory word
	logic                                      accept;
	logic                                      lastElem;
	logic                                      waitDone;

	// Blocked while the last result still waits for continue
	assign accept = (state == Idle) && ap_start && !doneHeld;
	assign lastElem = (index == (fp16Pkg::IndexWidth)'(fp16Pkg::NumElems));
	assign waitDone = (waitCnt == ($clog2(fp16Pkg::AddLatency))'(fp16Pkg::AddLatency - 1));

	always_comb begin
		stateNext = state;
		case (state)
			Idle: begin
				if (accept) begin
					stateNext = Fetch;
				end
			end
			Fetch: begin
				// All words summed, back to Idle
				if (lastElem) begin
					stateNext = Idle;
				end else begin
					stateNext = Load;
				end
			end
			Load: stateNext = Wait;       // Read data on the bus this cycle
			Wait: begin
				if (waitDone) begin
					stateNext = Accumulate;
				end
			end
			Accumulate: stateNext = Fetch;
			default: stateNext = Idle;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= Idle;
			index <= '0;
			waitCnt <= '0;
		end else begin
			state <= stateNext;
			if (accept) begin
				index <= '0;
			end else if (state == Accumulate) begin
				index <= index + 1'b1;
			end
			// Restarts from zero on every entry into Wait
			if (state == Wait) begin
				waitCnt <= waitCnt + 1'b1;
			end else begin
				waitCnt <= '0;
			end
		end
	end

	always_ff @(posedge ap_clk) begin
		if (state == Load) begin
			loadReg <= accumInQ;
		end
		// Sum starts from +0 for each run
		if (accept) begin
			runSum <= '0;
		end else if (state == Accumulate) begin
			runSum <= addResult;   // Adder has seen this word for AddLatency cycles
		end
	end

	assign accumInAddr = index[fp16Pkg::AddrWidth-1:0];
	assign accumInCe = (state == Fetch) && !lastElem;
	assign finish = (state == Fetch) && lastElem;
	assign ap_idle = (state == Idle) && !ap_start;
	assign opA = runSum;
	assign opB = loadReg;

endmodule

//--- accumResult.sv
`timescale 1ns/1ps

module accumResult (
	input  logic                ap_clk,
	input  logic                ap_rst,
	input  logic                finish,        // End of run pulse from sequencer
	input  fp16Pkg::halfWord_u  runSum,
	input  logic                ap_continue,
	output fp16Pkg::halfWord_u  accumSum,
	output logic                accumSumVld,
	output logic                ap_done,
	output logic                ap_ready,
	output logic                doneHeld
);

	fp16Pkg::halfWord_u heldSum;   // Last total, shown between runs

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			heldSum <= '0;
		end else if (finish) begin
			heldSum <= runSum;
		end
	end

	// Continue wins over a finish in the same cycle
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			doneHeld <= 1'b0;
		end else if (ap_continue) begin
			doneHeld <= 1'b0;
		end else if (finish) begin
			doneHeld <= 1'b1;
		end
	end

	// Total visible in the finish cycle itself
	assign accumSum = finish ? runSum : heldSum;
	assign accumSumVld = finish;
	assign ap_ready = finish;
	assign ap_done = finish | doneHeld;   // Stays up until continue

endmodule

//--- accumTop.sv
`timescale 1ns/1ps

module accumTop (
	input  logic                           ap_clk,
	input  logic                           ap_rst,
	input  logic                           ap_start,
	input  logic                           ap_continue,
	input  fp16Pkg::halfWord_u             accumInQ,
	output logic [fp16Pkg::AddrWidth-1:0]  accumInAddr,
	output logic                           accumInCe,
	output fp16Pkg::halfWord_u             accumSum,
	output logic                           accumSumVld,
	output logic                           ap_done,
	output logic                           ap_idle,
	output logic                           ap_ready
);

	fp16Pkg::halfWord_u   opA;
	fp16Pkg::halfWord_u   opB;
	fp16Pkg::halfWord_u   addResult;
	fp16Pkg::halfWord_u   runSum;
	logic                 finish;
	logic                 doneHeld;

	accumSequencer accumSequencerInst (
		.ap_clk      (ap_clk),
		.ap_rst      (ap_rst),
		.ap_start    (ap_start),
		.doneHeld    (doneHeld),
		.accumInQ    (accumInQ),
		.addResult   (addResult),
		.accumInAddr (accumInAddr),
		.accumInCe   (accumInCe),
		.ap_idle     (ap_idle),
		.opA         (opA),
		.opB         (opB),
		.finish      (finish),
		.runSum      (runSum)
	);

	// No valid in or out, sequencer samples at a fixed distance
	fpAddPipe fpAddPipeInst (
		.ap_clk    (ap_clk),
		.opA       (opA),
		.opB       (opB),
		.addResult (addResult)
	);

	accumResult accumResultInst (
		.ap_clk      (ap_clk),
		.ap_rst      (ap_rst),
		.finish      (finish),
		.runSum      (runSum),
		.ap_continue (ap_continue),
		.accumSum    (accumSum),
		.accumSumVld (accumSumVld),
		.ap_done     (ap_done),
		.ap_ready    (ap_ready),
		.doneHeld    (doneHeld)
	);

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int Period = 20,      // ns
	parameter int ResetCycles = 8
) (
	output logic ap_clk,
	output logic ap_rst
);

	initial begin
		ap_clk = 1'b0;
		forever #(Period / 2) ap_clk = ~ap_clk;
	end

	// Released on a falling edge, like every other DUT input
	initial begin
		ap_rst = 1'b1;
		repeat (ResetCycles) @(posedge ap_clk);
		@(negedge ap_clk);
		ap_rst = 1'b0;
	end

endmodule

//--- accumTb.sv
`timescale 1ns/1ps

module accumTb;

	localparam int Period = 20;
	localparam int ResetCycles = 8;
	localparam int NumRuns = 16;
	localparam int RunBudget = 60;                                 // Cycles allowed per run
	localparam int WatchdogCycles = 20 * RunBudget + ResetCycles;
	localparam int FinishDelay = 49;                               // Acceptance edge to finish
	localparam int WaitLimit = 100;

	logic                           ap_clk;
	logic                           ap_rst;
	logic                           ap_start;
	logic                           ap_continue;
	fp16Pkg::halfWord_u             accumInQ;
	logic [fp16Pkg::AddrWidth-1:0]  accumInAddr;
	logic                           accumInCe;
	fp16Pkg::halfWord_u             accumSum;
	logic                           accumSumVld;
	logic                           ap_done;
	logic                           ap_idle;
	logic                           ap_ready;

	fp16Pkg::halfWord_u             mem [fp16Pkg::NumElems];   // One read port memory model
	integer                         seed;
	int                             cycleCount;
	int                             finishCycle;    // Cycle of the expected strobe
	int                             readCount;
	bit                             runActive;      // Acceptance edge up to finish
	bit                             doneModel;      // Expected done latch
	bit                             prevFinish;
	bit                             readPending;
	logic [fp16Pkg::AddrWidth-1:0]  pendAddr;
	logic [fp16Pkg::AddrWidth-1:0]  expectAddr;
	fp16Pkg::halfWord_u             expectSum;
	fp16Pkg::halfWord_u             heldModel;      // What accumSum shows between runs

	tbClock #(.Period(Period), .ResetCycles(ResetCycles)) tbClockInst (
		.ap_clk (ap_clk),
		.ap_rst (ap_rst)
	);

	accumTop accumTop_inst (
		.ap_clk      (ap_clk),
		.ap_rst      (ap_rst),
		.ap_start    (ap_start),
		.ap_continue (ap_continue),
		.accumInQ    (accumInQ),
		.accumInAddr (accumInAddr),
		.accumInCe   (accumInCe),
		.accumSum    (accumSum),
		.accumSumVld (accumSumVld),
		.ap_done     (ap_done),
		.ap_idle     (ap_idle),
		.ap_ready    (ap_ready)
	);

	task automatic abortRun();
		$display("** FAIL **");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic compareWord(input string name, input fp16Pkg::halfWord_u got,
			input fp16Pkg::halfWord_u want);
		if (got.raw !== want.raw) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got.raw, want.raw);
			abortRun();
		end
	endtask

	task automatic compareBit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, want);
			abortRun();
		end
	endtask

	task automatic compareAddr(input string name, input logic [fp16Pkg::AddrWidth-1:0] got,
			input logic [fp16Pkg::AddrWidth-1:0] want);
		if (got !== want) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, want);
			abortRun();
		end
	endtask

	task automatic compareCount(input string name, input int got, input int want);
		if (got != want) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, want);
			abortRun();
		end
	endtask

	// One fp16 add in integer arithmetic in units of 1/32 of a mantissa step
	function automatic fp16Pkg::halfWord_u modelAdd(input fp16Pkg::halfWord_u a,
			input fp16Pkg::halfWord_u b);
		fp16Pkg::halfWord_u bigOp;
		fp16Pkg::halfWord_u smallOp;
		fp16Pkg::halfWord_u res;
		int sigBig;
		int sigSmall;
		int shift;
		int smallV;
		int s;
		int p;
		int drop;
		int kept;
		int rest;
		int half;
		int expo;
		bigOp = ({a.fields.exponent, a.fields.mantissa} >=
			{b.fields.exponent, b.fields.mantissa}) ? a : b;
		smallOp = (bigOp.raw == a.raw) ? b : a;
		// No hidden one at exp 0
		sigBig = int'({bigOp.fields.exponent != 0, bigOp.fields.mantissa});
		sigSmall = int'({smallOp.fields.exponent != 0, smallOp.fields.mantissa});
		shift = int'(bigOp.fields.exponent) - int'(smallOp.fields.exponent);
		smallV = (shift >= fp16Pkg::MaxAlignShift) ? 0 :
			((sigSmall << fp16Pkg::GuardBits) >> shift);
		if (bigOp.fields.sign == smallOp.fields.sign) begin
			s = (sigBig << fp16Pkg::GuardBits) + smallV;
		end else begin
			s = (sigBig << fp16Pkg::GuardBits) - smallV;
		end
		res.raw = '0;
		if (s == 0) begin
			// -0 only from two negatives
			res.fields.sign = bigOp.fields.sign & smallOp.fields.sign;
			return res;
		end
		p = 0;
		for (int i = 0; i < 32; i++) begin
			if (s[i]) p = i;   // Position of leading one
		end
		expo = int'(bigOp.fields.exponent) + p - (fp16Pkg::ManWidth + fp16Pkg::GuardBits);
		if (p > fp16Pkg::ManWidth) begin
			drop = p - fp16Pkg::ManWidth;
			kept = s >> drop;
			rest = s - (kept << drop);
			half = 1 << (drop - 1);
			// Nearest with ties to even
			if (rest > half || (rest == half && kept[0])) kept++;
			if (kept == (2 << fp16Pkg::ManWidth)) begin
				kept = kept >> 1;   // Round carried past the top
				expo++;
			end
		end else begin
			kept = s << (fp16Pkg::ManWidth - p);   // Exact after cancellation
		end
		res.fields.sign = bigOp.fields.sign;
		res.fields.exponent = (fp16Pkg::ExpWidth)'(expo);   // Wraps like the DUT
		res.fields.mantissa = (fp16Pkg::ManWidth)'(kept);
		return res;
	endfunction

	function automatic fp16Pkg::halfWord_u modelSum();
		fp16Pkg::halfWord_u acc;
		acc.raw = '0;
		for (int i = 0; i < fp16Pkg::NumElems; i++) begin
			acc = modelAdd(acc, mem[i]);   // Fetch order
		end
		return acc;
	endfunction

	function automatic fp16Pkg::halfWord_u randomWord(input int lowExp, input int span);
		fp16Pkg::halfWord_u w;
		w.fields.sign = 1'($random(seed));
		w.fields.exponent = (fp16Pkg::ExpWidth)'(lowExp + {$random(seed)} % span);
		w.fields.mantissa = (fp16Pkg::ManWidth)'($random(seed));
		return w;
	endfunction

	task automatic fillMemory(input int mode);
		for (int i = 0; i < fp16Pkg::NumElems; i++) begin
			if (mode == 1) begin
				mem[i] = randomWord(14, 3);   // Close exponents give many carries and ties
			end else if (mode == 3 && i % 2 == 1) begin
				mem[i] = mem[i - 1];          // Cancelling pair
				mem[i].fields.sign = ~mem[i - 1].fields.sign;
			end else begin
				mem[i] = randomWord(8, 15);
			end
		end
	endtask

	// Outputs sampled at the falling edge before the inputs change
	task automatic stepCycle();
		bit finishNow;
		@(negedge ap_clk);
		if (ap_continue) doneModel = 1'b0;   // Continue wins over finish
		else if (prevFinish) doneModel = 1'b1;
		cycleCount++;
		finishNow = (cycleCount == finishCycle);
		if (readPending) begin
			accumInQ = mem[pendAddr];   // Reply one cycle after the enable
			readPending = 1'b0;
		end else begin
			accumInQ.raw = 16'hffff;    // Junk outside reply cycles
		end
		if (accumInCe) begin
			if (!runActive) begin
				$display("Memory read issued while no run had been accepted");
				abortRun();
			end
			compareAddr("accumInAddr", accumInAddr, expectAddr);
			expectAddr++;
			readCount++;
			readPending = 1'b1;
			pendAddr = accumInAddr;
		end
		compareBit("accumSumVld", accumSumVld, finishNow);
		compareBit("ap_ready", ap_ready, finishNow);
		compareBit("ap_done", ap_done, finishNow | doneModel);
		compareBit("ap_idle", ap_idle, !runActive && !ap_start);
		if (finishNow) begin
			compareWord("accumSum", accumSum, expectSum);
			heldModel = expectSum;
			runActive = 1'b0;
		end else begin
			compareWord("accumSum", accumSum, heldModel);   // Held between runs
		end
		prevFinish = finishNow;
	endtask

	task automatic runOnce(input bit earlyContinue);
		int waited;
		expectSum = modelSum();
		readCount = 0;
		expectAddr = '0;
		ap_start = 1'b1;
		runActive = 1'b1;
		finishCycle = cycleCount + FinishDelay;   // Taken on the next rising edge
		stepCycle();
		ap_start = 1'b0;
		waited = 0;
		while (!accumSumVld) begin
			if (waited >= WaitLimit) begin
				$display("No valid strobe within %0d cycles of the start", WaitLimit);
				abortRun();
			end
			stepCycle();
			waited++;
		end
		compareCount("read count", readCount, fp16Pkg::NumElems);
		if (earlyContinue) begin
			ap_continue = 1'b1;   // Continue in the finish cycle keeps the latch clear
			stepCycle();
			ap_continue = 1'b0;
		end else begin
			ap_start = 1'b1;      // Start while done is still held
			repeat (5) stepCycle();
			ap_start = 1'b0;
			ap_continue = 1'b1;
			stepCycle();
			ap_continue = 1'b0;
			stepCycle();
		end
	endtask

	initial begin
		repeat (WatchdogCycles) @(posedge ap_clk);
		$display("Watchdog expired after %0d cycles, the DUT appears to hang", WatchdogCycles);
		$display("** FAIL **");
		$fatal(1, "Stopped by the watchdog");
	end

	initial begin
		seed = 32'h830fc64e;
		ap_start = 1'b0;
		ap_continue = 1'b0;
		accumInQ.raw = '0;
		cycleCount = 0;
		finishCycle = -1;
		readCount = 0;
		runActive = 1'b0;
		doneModel = 1'b0;
		prevFinish = 1'b0;
		readPending = 1'b0;
		pendAddr = '0;
		expectAddr = '0;
		expectSum.raw = '0;
		heldModel.raw = '0;   // Result register clears in reset
		@(negedge ap_rst);
		repeat (3) stepCycle();   // Quiet and idle after reset
		for (int r = 0; r < NumRuns; r++) begin
			fillMemory(r % 4);
			runOnce(r % 3 == 1);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

//--- build.f
fp16Pkg.sv
fpAlign.sv
fpNormalizeRound.sv
fpAddPipe.sv
accumSequencer.sv
accumResult.sv
accumTop.sv
tbClock.sv
accumTb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module accumTb -o accumSim

run: compile
	./obj_dir/accumSim | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
